// ==== design/knn_defs.svh ====
`ifndef KNN_DEFS_SVH
`define KNN_DEFS_SVH

// patch geometry
`define KNN_DATA_WIDTH      11
`define KNN_PATCH_SIZE      5
`define KNN_IDX_WIDTH       9      // index into the source image

// leaf storage
`define KNN_LEAF_SIZE       8
`define KNN_NUM_LEAVES      64
`define KNN_LEAF_ADDRW      6
`define KNN_SLOT_WIDTH      3

// results
`define KNN_K               4
`define KNN_DIST_WIDTH      25     // 5 squared 11-bit differences
`define KNN_RESULT_DEPTH    4

`endif

// ==== design/knn_pkg.sv ====
`include "knn_defs.svh"

package knn_pkg;

    typedef logic [`KNN_DATA_WIDTH-1:0] elem_t;
    typedef elem_t [`KNN_PATCH_SIZE-1:0] patch_t;
    typedef logic [`KNN_IDX_WIDTH-1:0] idx_t;
    typedef logic [`KNN_LEAF_ADDRW-1:0] leaf_addr_t;
    typedef logic [`KNN_SLOT_WIDTH-1:0] slot_t;
    typedef logic [`KNN_DIST_WIDTH-1:0] dist_t;

    // whole-leaf views, slot 0 in the low bits
    typedef patch_t [`KNN_LEAF_SIZE-1:0] leaf_patches_t;
    typedef idx_t [`KNN_LEAF_SIZE-1:0] leaf_idx_t;
    typedef dist_t [`KNN_LEAF_SIZE-1:0] cand_dist_t;
    typedef idx_t [`KNN_LEAF_SIZE-1:0] cand_idx_t;

    // entry 0 is the nearest
    typedef dist_t [`KNN_K-1:0] dist_list_t;
    typedef idx_t [`KNN_K-1:0] idx_list_t;

endpackage

// ==== design/leaf_mem.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module leaf_mem import knn_pkg::*; (
    input  logic          clk,
    input  logic          en,
    input  logic          we,
    input  leaf_addr_t    addr,
    input  slot_t         wslot,
    input  patch_t        wpatch,
    input  idx_t          widx,
    output leaf_patches_t rpatches,
    output leaf_idx_t     ridx
);

    patch_t patch_mem [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE];
    idx_t   idx_mem   [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE];

    // one slot written per access
    always_ff @(posedge clk) begin
        if (en && we) begin
            patch_mem[addr][wslot] <= wpatch;
            idx_mem[addr][wslot]   <= widx;
        end
    end

    // whole leaf read, data valid next cycle
    always_ff @(posedge clk) begin
        if (en && !we) begin
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                rpatches[s] <= patch_mem[addr][s];
                ridx[s]     <= idx_mem[addr][s];
            end
        end
    end

endmodule

// ==== design/leaf_mem_arbiter.sv ====
`timescale 1ns/1ps

module leaf_mem_arbiter import knn_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_valid,
    input  leaf_addr_t load_leaf,
    input  slot_t      load_slot,
    input  patch_t     load_patch,
    input  idx_t       load_idx,
    input  logic       fetch_req,
    input  leaf_addr_t fetch_leaf,
    output logic       load_ready,
    output logic       fetch_gnt,
    output logic       mem_en,
    output logic       mem_we,
    output leaf_addr_t mem_addr,
    output slot_t      mem_wslot,
    output patch_t     mem_wpatch,
    output idx_t       mem_widx
);

    logic last_was_load;   // who got the port last time

    // fetch wins a conflict only if load was served last
    assign fetch_gnt  = fetch_req && (!load_valid || last_was_load);
    assign load_ready = load_valid && !fetch_gnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_was_load <= 1'b0;
        end else if (fetch_gnt) begin
            last_was_load <= 1'b0;
        end else if (load_ready) begin
            last_was_load <= 1'b1;
        end
    end

    assign mem_en     = fetch_gnt || load_ready;
    assign mem_we     = load_ready;
    assign mem_addr   = fetch_gnt ? fetch_leaf : load_leaf;
    assign mem_wslot  = load_slot;
    assign mem_wpatch = load_patch;
    assign mem_widx   = load_idx;

endmodule

// ==== design/l2_kernel.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module l2_kernel import knn_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          query_valid,
    input  patch_t        query_patch,
    input  leaf_addr_t    query_leaf,
    input  logic          query_first,
    input  logic          query_last,
    input  logic          fetch_gnt,
    input  logic          room,
    input  leaf_patches_t rpatches,
    input  leaf_idx_t     ridx,
    output logic          query_ready,
    output logic          fetch_req,
    output leaf_addr_t    fetch_leaf,
    output logic          last_issued,
    output logic          dist_valid,
    output logic          dist_first,
    output logic          dist_last,
    output cand_dist_t    dists,
    output cand_idx_t     idxs
);

    logic   rd_valid;
    logic   rd_first;
    logic   rd_last;
    patch_t rd_patch;

    function automatic dist_t patch_dist(patch_t a, patch_t b);
        dist_t acc;
        elem_t diff;
        acc = '0;
        for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
            diff = (a[e] > b[e]) ? a[e] - b[e] : b[e] - a[e];
            acc  = acc + dist_t'(diff) * dist_t'(diff);
        end
        return acc;
    endfunction

    // a last beat only goes out when the result queue can hold it
    assign fetch_req   = query_valid && (!query_last || room);
    assign fetch_leaf  = query_leaf;
    assign query_ready = fetch_gnt;
    assign last_issued = query_valid && query_ready && query_last;

    // align query with leaf read data
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= query_valid && query_ready;
        end
        rd_first <= query_first;
        rd_last  <= query_last;
        rd_patch <= query_patch;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dist_valid <= 1'b0;
        end else begin
            dist_valid <= rd_valid;
        end
        dist_first <= rd_first;
        dist_last  <= rd_last;
        idxs       <= ridx;
        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
            dists[s] <= patch_dist(rd_patch, rpatches[s]);
        end
    end

endmodule

// ==== design/running_min.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module running_min import knn_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dist_valid,
    input  logic       dist_first,
    input  logic       dist_last,
    input  cand_dist_t dists,
    input  cand_idx_t  idxs,
    output logic       min_valid,
    output cand_dist_t min_dists,
    output cand_idx_t  min_idxs
);

    // one pulse per query, on its final leaf
    always_ff @(posedge clk) begin
        if (reset) begin
            min_valid <= 1'b0;
        end else begin
            min_valid <= dist_valid && dist_last;
        end
    end

    always_ff @(posedge clk) begin
        if (dist_valid) begin
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                if (dist_first) begin
                    min_dists[s] <= dists[s];  // restart
                    min_idxs[s]  <= idxs[s];
                end else if (dists[s] < min_dists[s]) begin
                    // strict compare keeps the earlier leaf on ties
                    min_dists[s] <= dists[s];
                    min_idxs[s]  <= idxs[s];
                end
            end
        end
    end

endmodule

// ==== design/bitonic_sorter.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module bitonic_sorter import knn_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       min_valid,
    input  cand_dist_t min_dists,
    input  cand_idx_t  min_idxs,
    output logic       sort_valid,
    output dist_list_t best_dists,
    output idx_list_t  best_idxs
);

    // key is distance then slot, so every key is unique
    localparam int KEY_W = `KNN_DIST_WIDTH + `KNN_SLOT_WIDTH;
    localparam int ENT_W = KEY_W + `KNN_IDX_WIDTH;

    logic             st1_valid;
    logic             st2_valid;
    logic [ENT_W-1:0] st1_d [`KNN_LEAF_SIZE];
    logic [ENT_W-1:0] st1_q [`KNN_LEAF_SIZE];
    logic [ENT_W-1:0] st2_d [`KNN_K];
    logic [ENT_W-1:0] st2_q [`KNN_K];
    logic [ENT_W-1:0] st3_d [`KNN_K];
    logic [ENT_W-1:0] st3_q [`KNN_K];

    function automatic logic [2*ENT_W-1:0] order(logic [ENT_W-1:0] a, logic [ENT_W-1:0] b,
                                                  logic up);
        logic a_first;
        a_first = (a[ENT_W-1 -: KEY_W] < b[ENT_W-1 -: KEY_W]) == up;
        return a_first ? {a, b} : {b, a};
    endfunction

    // stage 1: sort each half of four, low half up, high half down
    always_comb begin
        for (int i = 0; i < `KNN_LEAF_SIZE; i++) begin
            st1_d[i] = {min_dists[i], slot_t'(i), min_idxs[i]};
        end
        for (int g = 0; g < 2; g++) begin
            {st1_d[4*g], st1_d[4*g+1]}   = order(st1_d[4*g], st1_d[4*g+1], g == 0);
            {st1_d[4*g+2], st1_d[4*g+3]} = order(st1_d[4*g+2], st1_d[4*g+3], g != 0);
            {st1_d[4*g], st1_d[4*g+2]}   = order(st1_d[4*g], st1_d[4*g+2], g == 0);
            {st1_d[4*g+1], st1_d[4*g+3]} = order(st1_d[4*g+1], st1_d[4*g+3], g == 0);
            {st1_d[4*g], st1_d[4*g+1]}   = order(st1_d[4*g], st1_d[4*g+1], g == 0);
            {st1_d[4*g+2], st1_d[4*g+3]} = order(st1_d[4*g+2], st1_d[4*g+3], g == 0);
        end
    end

    // stage 2: half cleaner keeps the lower four, still bitonic
    always_comb begin
        for (int i = 0; i < `KNN_K; i++) begin
            if (st1_q[i][ENT_W-1 -: KEY_W] < st1_q[i+4][ENT_W-1 -: KEY_W]) begin
                st2_d[i] = st1_q[i];
            end else begin
                st2_d[i] = st1_q[i+4];
            end
        end
    end

    // stage 3: bitonic merge of four into ascending order
    always_comb begin
        for (int i = 0; i < `KNN_K; i++) begin
            st3_d[i] = st2_q[i];
        end
        {st3_d[0], st3_d[2]} = order(st3_d[0], st3_d[2], 1'b1);
        {st3_d[1], st3_d[3]} = order(st3_d[1], st3_d[3], 1'b1);
        {st3_d[0], st3_d[1]} = order(st3_d[0], st3_d[1], 1'b1);
        {st3_d[2], st3_d[3]} = order(st3_d[2], st3_d[3], 1'b1);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid  <= 1'b0;
            st2_valid  <= 1'b0;
            sort_valid <= 1'b0;
        end else begin
            st1_valid  <= min_valid;
            st2_valid  <= st1_valid;
            sort_valid <= st2_valid;
        end
        st1_q <= st1_d;
        st2_q <= st2_d;
        st3_q <= st3_d;
    end

    always_comb begin
        for (int k = 0; k < `KNN_K; k++) begin
            best_dists[k] = st3_q[k][ENT_W-1 -: `KNN_DIST_WIDTH];
            best_idxs[k]  = st3_q[k][`KNN_IDX_WIDTH-1:0];
        end
    end

endmodule

// ==== design/result_queue.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module result_queue import knn_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       last_issued,
    input  logic       sort_valid,
    input  dist_list_t best_dists,
    input  idx_list_t  best_idxs,
    input  logic       result_ready,
    output logic       room,
    output logic       result_valid,
    output dist_list_t result_dist,
    output idx_list_t  result_idx
);

    localparam int PTR_W = $clog2(`KNN_RESULT_DEPTH);
    localparam int CNT_W = $clog2(`KNN_RESULT_DEPTH + 1);

    dist_list_t       dist_mem [`KNN_RESULT_DEPTH];
    idx_list_t        idx_mem  [`KNN_RESULT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // stored entries
    logic [CNT_W-1:0] used;    // reserved plus stored
    logic             empty;
    logic             push;
    logic             pop;

    assign empty = (count == '0);
    // empty queue passes a fresh result straight to the port
    assign push  = sort_valid && !(empty && result_ready);
    assign pop   = result_ready && !empty;

    assign result_valid = !empty || sort_valid;
    assign result_dist  = empty ? best_dists : dist_mem[rd_ptr];
    assign result_idx   = empty ? best_idxs : idx_mem[rd_ptr];
    assign room         = used < CNT_W'(`KNN_RESULT_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            used   <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            used   <= used + CNT_W'(last_issued) - CNT_W'(result_valid && result_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            dist_mem[wr_ptr] <= best_dists;
            idx_mem[wr_ptr]  <= best_idxs;
        end
    end

endmodule

// ==== design/knn_top.sv ====
`timescale 1ns/1ps

module knn_top import knn_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // leaf load stream
    input  logic       load_valid,
    input  leaf_addr_t load_leaf,
    input  slot_t      load_slot,
    input  patch_t     load_patch,
    input  idx_t       load_idx,
    output logic       load_ready,

    // query beats
    input  logic       query_valid,
    input  patch_t     query_patch,
    input  leaf_addr_t query_leaf,
    input  logic       query_first,
    input  logic       query_last,
    output logic       query_ready,

    // k best per query
    output logic       result_valid,
    output dist_list_t result_dist,
    output idx_list_t  result_idx,
    input  logic       result_ready
);

    logic          fetch_req;
    logic          fetch_gnt;
    leaf_addr_t    fetch_leaf;
    logic          mem_en;
    logic          mem_we;
    leaf_addr_t    mem_addr;
    slot_t         mem_wslot;
    patch_t        mem_wpatch;
    idx_t          mem_widx;
    leaf_patches_t rpatches;
    leaf_idx_t     ridx;

    logic          last_issued;
    logic          room;
    logic          dist_valid;
    logic          dist_first;
    logic          dist_last;
    cand_dist_t    dists;
    cand_idx_t     idxs;
    logic          min_valid;
    cand_dist_t    min_dists;
    cand_idx_t     min_idxs;
    logic          sort_valid;
    dist_list_t    best_dists;
    idx_list_t     best_idxs;

    leaf_mem leaf_mem_inst (
        .clk      (clk),
        .en       (mem_en),
        .we       (mem_we),
        .addr     (mem_addr),
        .wslot    (mem_wslot),
        .wpatch   (mem_wpatch),
        .widx     (mem_widx),
        .rpatches (rpatches),
        .ridx     (ridx)
    );

    leaf_mem_arbiter leaf_mem_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_leaf  (load_leaf),
        .load_slot  (load_slot),
        .load_patch (load_patch),
        .load_idx   (load_idx),
        .fetch_req  (fetch_req),
        .fetch_leaf (fetch_leaf),
        .load_ready (load_ready),
        .fetch_gnt  (fetch_gnt),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wslot  (mem_wslot),
        .mem_wpatch (mem_wpatch),
        .mem_widx   (mem_widx)
    );

    l2_kernel l2_kernel_inst (
        .clk         (clk),
        .reset       (reset),
        .query_valid (query_valid),
        .query_patch (query_patch),
        .query_leaf  (query_leaf),
        .query_first (query_first),
        .query_last  (query_last),
        .fetch_gnt   (fetch_gnt),
        .room        (room),
        .rpatches    (rpatches),
        .ridx        (ridx),
        .query_ready (query_ready),
        .fetch_req   (fetch_req),
        .fetch_leaf  (fetch_leaf),
        .last_issued (last_issued),
        .dist_valid  (dist_valid),
        .dist_first  (dist_first),
        .dist_last   (dist_last),
        .dists       (dists),
        .idxs        (idxs)
    );

    running_min running_min_inst (
        .clk        (clk),
        .reset      (reset),
        .dist_valid (dist_valid),
        .dist_first (dist_first),
        .dist_last  (dist_last),
        .dists      (dists),
        .idxs       (idxs),
        .min_valid  (min_valid),
        .min_dists  (min_dists),
        .min_idxs   (min_idxs)
    );

    bitonic_sorter bitonic_sorter_inst (
        .clk        (clk),
        .reset      (reset),
        .min_valid  (min_valid),
        .min_dists  (min_dists),
        .min_idxs   (min_idxs),
        .sort_valid (sort_valid),
        .best_dists (best_dists),
        .best_idxs  (best_idxs)
    );

    result_queue result_queue_inst (
        .clk          (clk),
        .reset        (reset),
        .last_issued  (last_issued),
        .sort_valid   (sort_valid),
        .best_dists   (best_dists),
        .best_idxs    (best_idxs),
        .result_ready (result_ready),
        .room         (room),
        .result_valid (result_valid),
        .result_dist  (result_dist),
        .result_idx   (result_idx)
    );

endmodule

// ==== sim/knn_tb.sv ====
`timescale 1ns/1ps
`include "knn_defs.svh"

module knn_tb import knn_pkg::*; ();

    localparam int HANDSHAKE_LIMIT = 1000;   // cycles per port handshake
    localparam int RESULT_LIMIT    = 2000;   // idle cycles between results

    logic       clk;
    logic       reset;
    logic       load_valid;
    leaf_addr_t load_leaf;
    slot_t      load_slot;
    patch_t     load_patch;
    idx_t       load_idx;
    logic       load_ready;
    logic       query_valid;
    patch_t     query_patch;
    leaf_addr_t query_leaf;
    logic       query_first;
    logic       query_last;
    logic       query_ready;
    logic       result_valid;
    dist_list_t result_dist;
    idx_list_t  result_idx;
    logic       result_ready;

    // load and query records in file order
    logic [7:0] rec_kind  [$];
    leaf_addr_t rec_leaf  [$];
    slot_t      rec_slot  [$];
    logic       rec_first [$];
    logic       rec_last  [$];
    patch_t     rec_patch [$];
    idx_t       rec_idx   [$];
    dist_list_t exp_dist  [$];
    idx_list_t  exp_idx   [$];

    // reference model state
    patch_t     ref_patch [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE];
    idx_t       ref_idx   [`KNN_NUM_LEAVES][`KNN_LEAF_SIZE];
    dist_t      run_dist  [`KNN_LEAF_SIZE];
    idx_t       run_idx   [`KNN_LEAF_SIZE];
    dist_list_t ref_best_d;
    idx_list_t  ref_best_i;

    int dut_errors;
    int data_errors;
    int results_seen;

    knn_top knn_top_inst (
        .clk          (clk),
        .reset        (reset),
        .load_valid   (load_valid),
        .load_leaf    (load_leaf),
        .load_slot    (load_slot),
        .load_patch   (load_patch),
        .load_idx     (load_idx),
        .load_ready   (load_ready),
        .query_valid  (query_valid),
        .query_patch  (query_patch),
        .query_leaf   (query_leaf),
        .query_first  (query_first),
        .query_last   (query_last),
        .query_ready  (query_ready),
        .result_valid (result_valid),
        .result_dist  (result_dist),
        .result_idx   (result_idx),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string what);
        $display("%s", what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check_dist(dist_list_t got, dist_list_t exp, int n);
        if (got !== exp) begin
            $display("FAIL at time %0t: result %0d distances %p, expected %p", $time, n, got, exp);
            dut_errors++;
        end
    endtask

    task automatic check_idx(idx_list_t got, idx_list_t exp, int n);
        if (got !== exp) begin
            $display("FAIL at time %0t: result %0d indices %p, expected %p", $time, n, got, exp);
            dut_errors++;
        end
    endtask

    function automatic dist_t sq_l2(patch_t a, patch_t b);
        int acc;
        int d;
        acc = 0;
        for (int e = 0; e < `KNN_PATCH_SIZE; e++) begin
            d   = int'(a[e]) - int'(b[e]);
            acc = acc + d * d;
        end
        return dist_t'(acc);
    endfunction

    // smallest distance first, lower slot wins a tie
    task automatic select_top_k();
        logic [`KNN_LEAF_SIZE-1:0] taken;
        int best;
        taken = '0;
        for (int k = 0; k < `KNN_K; k++) begin
            best = -1;
            for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                if (!taken[s] && (best < 0 || run_dist[s] < run_dist[best])) begin
                    best = s;
                end
            end
            taken[best]   = 1'b1;
            ref_best_d[k] = run_dist[best];
            ref_best_i[k] = run_idx[best];
        end
    endtask

    task automatic read_testdata();
        int fd;
        int code;
        int v [8];
        logic [7:0] tag;
        patch_t p;
        dist_t d;
        dist_list_t fd_d;
        idx_list_t fd_i;
        fd = $fopen("sim/knn_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/knn_testdata.txt");
        end else begin
            code = $fscanf(fd, " %c", tag);
            while (code == 1) begin
                if (tag == "#") begin
                    while (code == 1 && tag != 8'd10) begin
                        code = $fscanf(fd, "%c", tag);
                    end
                end else begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d %d",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (tag == "L") begin
                        for (int e = 0; e < `KNN_PATCH_SIZE; e++) p[e] = elem_t'(v[2+e]);
                        rec_kind.push_back(tag);
                        rec_leaf.push_back(leaf_addr_t'(v[0]));
                        rec_slot.push_back(slot_t'(v[1]));
                        rec_first.push_back(1'b0);
                        rec_last.push_back(1'b0);
                        rec_patch.push_back(p);
                        rec_idx.push_back(idx_t'(v[7]));
                        ref_patch[v[0]][v[1]] = p;
                        ref_idx[v[0]][v[1]]   = idx_t'(v[7]);
                    end else if (tag == "Q") begin
                        for (int e = 0; e < `KNN_PATCH_SIZE; e++) p[e] = elem_t'(v[3+e]);
                        rec_kind.push_back(tag);
                        rec_leaf.push_back(leaf_addr_t'(v[0]));
                        rec_slot.push_back('0);
                        rec_first.push_back(v[1] != 0);
                        rec_last.push_back(v[2] != 0);
                        rec_patch.push_back(p);
                        rec_idx.push_back('0);
                        for (int s = 0; s < `KNN_LEAF_SIZE; s++) begin
                            d = sq_l2(p, ref_patch[v[0]][s]);
                            if (v[1] != 0 || d < run_dist[s]) begin   // earlier leaf kept on tie
                                run_dist[s] = d;
                                run_idx[s]  = ref_idx[v[0]][s];
                            end
                        end
                        if (v[2] != 0) select_top_k();
                    end else begin
                        for (int k = 0; k < `KNN_K; k++) begin
                            fd_d[k] = dist_t'(v[k]);
                            fd_i[k] = idx_t'(v[4+k]);
                        end
                        if (fd_d !== ref_best_d || fd_i !== ref_best_i) begin
                            $display("FAIL at time %0t: test data result %0d disagrees with model",
                                     $time, exp_dist.size());
                            data_errors++;
                        end
                        exp_dist.push_back(fd_d);
                        exp_idx.push_back(fd_i);
                    end
                end
                code = $fscanf(fd, " %c", tag);   // next record tag
            end
            $fclose(fd);
        end
    endtask

    // entered and left a fixed delay after a rising edge
    task automatic drive_load(int r);
        int waited;
        logic done;
        load_valid = 1'b1;
        load_leaf  = rec_leaf[r];
        load_slot  = rec_slot[r];
        load_patch = rec_patch[r];
        load_idx   = rec_idx[r];
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = load_ready;
            @(posedge clk);
            #10;
            waited++;
            if (!done && waited > HANDSHAKE_LIMIT) abort_run("timeout: load port never became ready");
        end
        load_valid = 1'b0;
    endtask

    task automatic drive_query(int r);
        int waited;
        logic done;
        query_valid = 1'b1;
        query_leaf  = rec_leaf[r];
        query_first = rec_first[r];
        query_last  = rec_last[r];
        query_patch = rec_patch[r];
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = query_ready;
            @(posedge clk);
            #10;
            waited++;
            if (!done && waited > HANDSHAKE_LIMIT) abort_run("timeout: query port never became ready");
        end
        query_valid = 1'b0;
    endtask

    task automatic drive_records();
        int r;
        r = 0;
        while (r < rec_kind.size()) begin
            // a load next to a query on another leaf goes out in the same cycle
            if (rec_kind[r] == "L" && r + 1 < rec_kind.size() && rec_kind[r+1] == "Q" &&
                rec_leaf[r+1] != rec_leaf[r]) begin
                fork
                    drive_load(r);
                    drive_query(r + 1);
                join
                r += 2;
            end else if (rec_kind[r] == "L") begin
                drive_load(r);
                r++;
            end else begin
                drive_query(r);
                r++;
            end
        end
    endtask

    task automatic collect_results();
        int idle;
        idle = 0;
        while (results_seen < exp_dist.size()) begin
            @(posedge clk);
            #10;
            result_ready = ($urandom % 3) == 0;   // frequent stalls
            @(negedge clk);
            if (result_valid && result_ready) begin
                check_dist(result_dist, exp_dist[results_seen], results_seen);
                check_idx(result_idx, exp_idx[results_seen], results_seen);
                results_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > RESULT_LIMIT) abort_run("timeout: no result came out of the result port");
            end
        end
    endtask

    task automatic check_no_extra();
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            #10;
            result_ready = 1'b1;
            @(negedge clk);
            if (result_valid) begin
                $display("FAIL at time %0t: result port offers an unexpected extra result", $time);
                dut_errors++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h9323_82e5));
        dut_errors   = 0;
        data_errors  = 0;
        results_seen = 0;
        reset        = 1'b1;
        load_valid   = 1'b0;
        load_leaf    = '0;
        load_slot    = '0;
        load_patch   = '0;
        load_idx     = '0;
        query_valid  = 1'b0;
        query_patch  = '0;
        query_leaf   = '0;
        query_first  = 1'b0;
        query_last   = 1'b0;
        result_ready = 1'b0;
        read_testdata();
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
        fork
            drive_records();
            collect_results();
        join
        check_no_extra();
        $display("results %0d of %0d, dut errors %0d, test data errors %0d",
                 results_seen, exp_dist.size(), dut_errors, data_errors);
        if (dut_errors == 0 && data_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/knn_testdata.txt ====
# L leaf slot e0 e1 e2 e3 e4 index  |  Q leaf first last e0 e1 e2 e3 e4
# E dist0 dist1 dist2 dist3 idx0 idx1 idx2 idx3, nearest first
L 0 0 10 10 10 10 10 100
L 0 1 20 0 0 0 0 101
L 0 2 0 0 0 0 0 102
L 0 3 5 5 5 5 5 103
L 0 4 2047 2047 2047 2047 2047 104
L 0 5 1 2 3 4 5 105
L 0 6 100 0 0 0 0 106
L 0 7 0 0 0 0 30 107
L 1 0 3 3 3 3 3 200
L 1 1 20 0 0 0 0 201
L 1 2 0 0 0 0 0 202
L 1 3 2 2 2 2 2 203
L 1 4 0 0 0 0 9 204
L 1 5 7 0 0 0 0 205
L 1 6 50 0 0 0 0 206
L 1 7 0 0 0 0 30 207
L 2 0 100 100 100 100 100 300
L 2 1 101 100 100 100 100 301
L 2 2 100 100 100 100 100 302
L 2 3 99 100 100 100 100 303
L 2 4 100 100 100 100 100 304
L 2 5 200 100 100 100 100 305
L 2 6 100 100 100 100 99 306
L 2 7 0 0 0 0 0 307
Q 0 1 1 0 0 0 0 0
E 0 55 125 400 102 105 103 101
Q 0 1 0 0 0 0 0 0
Q 1 0 1 0 0 0 0 0
E 0 20 45 49 102 203 200 205
Q 1 1 0 0 0 0 0 0
Q 0 0 1 0 0 0 0 0
E 0 20 45 49 202 203 200 205
Q 2 1 1 100 100 100 100 100
E 0 0 0 1 300 302 304 301
Q 2 1 1 0 0 0 0 0
E 0 49801 49801 50000 307 303 306 300
Q 0 1 1 10 10 10 10 10
E 0 125 255 500 100 103 105 101
L 3 0 70 0 0 0 0 400
Q 0 1 1 0 0 0 0 0
E 0 55 125 400 102 105 103 101
L 3 1 30 0 0 0 0 401
Q 2 1 1 100 100 100 100 100
E 0 0 0 1 300 302 304 301
L 3 2 50 0 0 0 0 402
L 3 3 10 0 0 0 0 403
L 3 4 60 0 0 0 0 404
L 3 5 20 0 0 0 0 405
L 3 6 40 0 0 0 0 406
L 3 7 0 0 0 0 0 407
Q 3 1 1 25 0 0 0 0
E 25 25 225 225 401 405 403 406
L 0 2 500 500 500 500 500 120
Q 0 1 1 0 0 0 0 0
E 55 125 400 500 105 103 101 100

// ==== project.f ====
+incdir+design
design/knn_pkg.sv
design/leaf_mem.sv
design/leaf_mem_arbiter.sv
design/l2_kernel.sv
design/running_min.sv
design/bitonic_sorter.sv
design/result_queue.sv
design/knn_top.sv
sim/knn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the knn testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module knn_tb -o knn_sim \
    && ./obj_dir/knn_sim | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
